// ==== src.f ====
+incdir+hdl
hdl/ps2_frame_pkg.sv
hdl/key_event_pkg.sv
hdl/ps2_frame_rx.sv
hdl/scan_decoder.sv
hdl/ascii_mapper.sv
hdl/ps2_keyboard_top.sv
test/ps2_keyboard_tb.sv

// ==== Bender.yml ====
package:
  name: ps2_keyboard

sources:
  # synthesizable sources
  - include_dirs:
      - hdl
    files:
      - hdl/ps2_frame_pkg.sv
      - hdl/key_event_pkg.sv
      - hdl/ps2_frame_rx.sv
      - hdl/scan_decoder.sv
      - hdl/ascii_mapper.sv
      - hdl/ps2_keyboard_top.sv
  # simulation only
  - target: test
    include_dirs:
      - hdl
    files:
      - test/ps2_keyboard_tb.sv

// ==== test/ps2_keyboard_tb.sv ====
`timescale 1ns/1ps
`include "ps2_settings.svh"

module ps2_keyboard_tb;
    import key_event_pkg::*;

    localparam int HALF_BIT     = 8;
    localparam int N_ACTIONS    = 200;
    localparam int N_PARTIAL    = 4;
    // worst case 5 frames per random action plus the directed frames
    localparam int MAX_FRAMES   = N_ACTIONS * 5 + 120;
    localparam int MAX_GAP      = 36;
    localparam int PARTIAL_IDLE = `PS2_IDLE_LIMIT + 64;
    localparam int CYCLE_LIMIT  = MAX_FRAMES * (`PS2_FRAME_BITS * 2 * HALF_BIT + MAX_GAP)
                                + N_PARTIAL * PARTIAL_IDLE + 2 * `PS2_IDLE_LIMIT;

    logic       clk;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    ascii_out_t key_out;
    logic       frame_error;

    integer     seed;
    int         cycles;
    string      cur_test;
    int         test_errs;
    int         pass_count;
    int         fail_count;
    int         exp_errors;
    int         seen_errors;
    ascii_out_t exp_q[$];

    // model state
    logic m_ext;
    logic m_rel;
    logic m_lshift;
    logic m_rshift;
    logic m_caps;

    // set 2 codes for a..z and 0..9
    logic [7:0] letter_codes [26] = '{8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34,
        8'h33, 8'h43, 8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A};
    logic [7:0] digit_codes [10] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36,
        8'h3D, 8'h3E, 8'h46};
    // arrows, keypad enter, gui
    logic [7:0] ext_codes [6] = '{8'h75, 8'h72, 8'h6B, 8'h74, 8'h5A, 8'h1F};

    ps2_keyboard_top dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .key_out     (key_out),
        .frame_error (frame_error)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic logic [7:0] expect_ascii(input logic [7:0] code, input logic ext,
                                                input logic up);
        logic [7:0] res;
        res = 8'h00;
        if (!ext) begin
            for (int i = 0; i < 26; i++) begin
                if (letter_codes[i] == code) begin
                    res = (up ? 8'h41 : 8'h61) + 8'(i);
                end
            end
            for (int i = 0; i < 10; i++) begin
                if (digit_codes[i] == code) begin
                    res = 8'h30 + 8'(i);
                end
            end
            if (code == 8'h29) begin
                res = 8'h20;
            end else if (code == 8'h5A) begin
                res = 8'h0D;
            end else if (code == 8'h66) begin
                res = 8'h08;
            end
        end
        return res;
    endfunction

    // index 0..38 over letters, digits, space, enter, backspace
    function automatic logic [7:0] mapped_code(input int idx);
        if (idx < 26) begin
            return letter_codes[idx];
        end else if (idx < 36) begin
            return digit_codes[idx - 26];
        end else if (idx == 36) begin
            return 8'h29;
        end else if (idx == 37) begin
            return 8'h5A;
        end
        return 8'h66;
    endfunction

    task automatic model_byte(input logic [7:0] data);
        ascii_out_t exp;
        logic       is_mod;
        is_mod = 1'b0;
        if (data == `SCAN_EXTENDED) begin
            m_ext = 1'b1;
        end else if (data == `SCAN_BREAK) begin
            m_rel = 1'b1;
        end else begin
            if (!m_ext && data == `SCAN_LSHIFT) begin
                m_lshift = !m_rel;
                is_mod   = 1'b1;
            end
            if (!m_ext && data == `SCAN_RSHIFT) begin
                m_rshift = !m_rel;
                is_mod   = 1'b1;
            end
            if (!m_ext && data == `SCAN_CAPS) begin
                // toggle on make only
                if (!m_rel) begin
                    m_caps = !m_caps;
                end
                is_mod = 1'b1;
            end
            if (!is_mod) begin
                exp.valid    = 1'b1;
                exp.released = m_rel;
                exp.extended = m_ext;
                exp.shift    = m_lshift | m_rshift;
                exp.caps     = m_caps;
                exp.code     = data;
                exp.ascii    = expect_ascii(data, m_ext, exp.shift ^ m_caps);
                exp_q.push_back(exp);
            end
            m_ext = 1'b0;
            m_rel = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // ps2 device side
    // --------------------------------------------------
    // corrupt 0 is none, 1 parity, 2 start, 3 stop
    task automatic send_frame(input logic [7:0] data, input int corrupt, input int nbits);
        logic [`PS2_FRAME_BITS-1:0] bits;
        bits = {1'b1, ~^data, data, 1'b0};
        if (corrupt == 1) begin
            bits[9] = ~bits[9];
        end else if (corrupt == 2) begin
            bits[0] = 1'b1;
        end else if (corrupt == 3) begin
            bits[`PS2_FRAME_BITS-1] = 1'b0;
        end
        for (int i = 0; i < nbits; i++) begin
            // data settles while the ps2 clock is high
            ps2_data = bits[i];
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (HALF_BIT) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
    endtask

    task automatic idle_gap(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_good(input logic [7:0] data);
        model_byte(data);
        send_frame(data, 0, `PS2_FRAME_BITS);
        idle_gap(4 + $unsigned($random(seed)) % 32);
    endtask

    task automatic send_bad(input logic [7:0] data, input int corrupt);
        // damaged frame drops pending prefixes
        m_ext = 1'b0;
        m_rel = 1'b0;
        exp_errors++;
        send_frame(data, corrupt, `PS2_FRAME_BITS);
        idle_gap(4 + $unsigned($random(seed)) % 32);
    endtask

    task automatic send_partial(input logic [7:0] data, input int nbits);
        send_frame(data, 0, nbits);
        idle_gap(PARTIAL_IDLE);
    endtask

    task automatic tap_key(input logic [7:0] code);
        send_good(code);
        send_good(`SCAN_BREAK);
        send_good(code);
    endtask

    task automatic random_action;
        int         kind;
        logic [7:0] code;
        kind = $unsigned($random(seed)) % 16;
        if (kind == 0) begin
            // toggle the held state of left shift
            if (m_lshift) begin
                send_good(`SCAN_BREAK);
            end
            send_good(`SCAN_LSHIFT);
        end else if (kind == 1) begin
            if (m_rshift) begin
                send_good(`SCAN_BREAK);
            end
            send_good(`SCAN_RSHIFT);
        end else if (kind == 2) begin
            tap_key(`SCAN_CAPS);
        end else if (kind == 3) begin
            code = ext_codes[$unsigned($random(seed)) % 6];
            send_good(`SCAN_EXTENDED);
            send_good(code);
            send_good(`SCAN_EXTENDED);
            send_good(`SCAN_BREAK);
            send_good(code);
        end else begin
            tap_key(mapped_code($unsigned($random(seed)) % 39));
        end
    endtask

    // --------------------------------------------------
    // compare and bookkeeping
    // --------------------------------------------------
    task automatic check_key(input ascii_out_t exp, input ascii_out_t act);
        if (act !== exp) begin
            $display("mismatch in %s: expected %h, actual %h", cur_test, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_err_count(input int exp, input int act);
        if (act != exp) begin
            $display("mismatch in %s: frame errors expected %0d, actual %0d",
                     cur_test, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test;
        // wait for outstanding events
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        check_err_count(exp_errors, seen_errors);
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
            pass_count++;
        end else begin
            $display("test %s: failed with %0d errors", cur_test, test_errs);
            fail_count++;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (key_out.valid) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected key event in %s, code %h, none was expected",
                             cur_test, key_out.code);
                    test_errs++;
                end else begin
                    check_key(exp_q.pop_front(), key_out);
                end
            end
            if (frame_error) begin
                seen_errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles in %s", cycles, cur_test);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        seed        = 32'hdf3e_2455;
        clk         = 1'b0;
        rst_n       = 1'b0;
        ps2_clk     = 1'b1;
        ps2_data    = 1'b1;
        cycles      = 0;
        cur_test    = "reset";
        test_errs   = 0;
        pass_count  = 0;
        fail_count  = 0;
        exp_errors  = 0;
        seen_errors = 0;
        m_ext       = 1'b0;
        m_rel       = 1'b0;
        m_lshift    = 1'b0;
        m_rshift    = 1'b0;
        m_caps      = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        idle_gap(4);

        start_test("make_codes");
        for (int i = 0; i < 36; i += 5) begin
            send_good(mapped_code(i));
        end
        // space, enter and backspace
        for (int i = 36; i < 39; i++) begin
            send_good(mapped_code(i));
        end
        end_test();

        start_test("break_codes");
        for (int i = 2; i < 39; i += 6) begin
            send_good(`SCAN_BREAK);
            send_good(mapped_code(i));
        end
        end_test();

        start_test("modifiers");
        send_good(`SCAN_LSHIFT);
        tap_key(8'h1C);
        send_good(`SCAN_BREAK);
        send_good(`SCAN_LSHIFT);
        tap_key(8'h1C);
        send_good(`SCAN_RSHIFT);
        tap_key(8'h16);
        // caps on top of shift gives lower case
        tap_key(`SCAN_CAPS);
        tap_key(8'h32);
        send_good(`SCAN_BREAK);
        send_good(`SCAN_RSHIFT);
        tap_key(8'h32);
        tap_key(`SCAN_CAPS);
        tap_key(8'h1A);
        end_test();

        start_test("extended");
        for (int i = 0; i < 6; i++) begin
            send_good(`SCAN_EXTENDED);
            send_good(ext_codes[i]);
            send_good(`SCAN_EXTENDED);
            send_good(`SCAN_BREAK);
            send_good(ext_codes[i]);
        end
        end_test();

        start_test("bad_frames");
        send_good(`SCAN_BREAK);
        send_bad(8'h1C, 1);
        send_good(8'h1C);
        send_good(`SCAN_EXTENDED);
        send_bad(8'h75, 2);
        send_good(8'h24);
        send_good(`SCAN_BREAK);
        send_bad(8'h29, 3);
        send_good(8'h29);
        end_test();

        start_test("abandoned_frames");
        for (int i = 0; i < N_PARTIAL; i++) begin
            send_partial(8'($random(seed)), 1 + $unsigned($random(seed)) % 10);
            tap_key(mapped_code($unsigned($random(seed)) % 39));
        end
        end_test();

        start_test("random_actions");
        for (int i = 0; i < N_ACTIONS; i++) begin
            random_action();
        end
        end_test();

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hdl/ps2_keyboard_top.sv ====
`timescale 1ns/1ps

module ps2_keyboard_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ps2_clk,
    input  logic                      ps2_data,
    output key_event_pkg::ascii_out_t key_out,
    output logic                      frame_error
);
    import ps2_frame_pkg::*;
    import key_event_pkg::*;

    ps2_byte_t  rx_byte;
    key_event_t key_event;

    // --------------------------------------------------
    // pin -> byte -> key event -> ascii
    // --------------------------------------------------
    ps2_frame_rx u_frame_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rx_byte  (rx_byte)
    );

    scan_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_byte   (rx_byte),
        .key_event (key_event)
    );

    ascii_mapper u_mapper (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_event (key_event),
        .key_out   (key_out)
    );

    // bad frame strobe straight out
    assign frame_error = rx_byte.error;

endmodule

// ==== hdl/ascii_mapper.sv ====
`timescale 1ns/1ps

module ascii_mapper (
    input  logic                      clk,
    input  logic                      rst_n,
    input  key_event_pkg::key_event_t key_event,
    output key_event_pkg::ascii_out_t key_out
);
    import key_event_pkg::*;

    logic [7:0] base_ascii;
    logic       is_letter;
    logic       upper;
    logic [7:0] ascii_next;

    // --------------------------------------------------
    // set 2 lookup, letters in lower case
    // --------------------------------------------------
    always_comb begin
        case (key_event.code)
            8'h1C: base_ascii = "a";
            8'h32: base_ascii = "b";
            8'h21: base_ascii = "c";
            8'h23: base_ascii = "d";
            8'h24: base_ascii = "e";
            8'h2B: base_ascii = "f";
            8'h34: base_ascii = "g";
            8'h33: base_ascii = "h";
            8'h43: base_ascii = "i";
            8'h3B: base_ascii = "j";
            8'h42: base_ascii = "k";
            8'h4B: base_ascii = "l";
            8'h3A: base_ascii = "m";
            8'h31: base_ascii = "n";
            8'h44: base_ascii = "o";
            8'h4D: base_ascii = "p";
            8'h15: base_ascii = "q";
            8'h2D: base_ascii = "r";
            8'h1B: base_ascii = "s";
            8'h2C: base_ascii = "t";
            8'h3C: base_ascii = "u";
            8'h2A: base_ascii = "v";
            8'h1D: base_ascii = "w";
            8'h22: base_ascii = "x";
            8'h35: base_ascii = "y";
            8'h1A: base_ascii = "z";
            // top row digits
            8'h45: base_ascii = "0";
            8'h16: base_ascii = "1";
            8'h1E: base_ascii = "2";
            8'h26: base_ascii = "3";
            8'h25: base_ascii = "4";
            8'h2E: base_ascii = "5";
            8'h36: base_ascii = "6";
            8'h3D: base_ascii = "7";
            8'h3E: base_ascii = "8";
            8'h46: base_ascii = "9";
            8'h29: base_ascii = ASCII_SPACE;
            8'h5A: base_ascii = ASCII_ENTER;
            8'h66: base_ascii = ASCII_BACKSPACE;
            default: base_ascii = ASCII_NONE;
        endcase
    end

    // case only matters for letters
    assign is_letter = (base_ascii >= "a") && (base_ascii <= "z");
    assign upper     = key_event.shift ^ key_event.caps;

    // extended keys share codes with plain ones, never mapped
    always_comb begin
        if (key_event.extended) begin
            ascii_next = ASCII_NONE;
        end else if (is_letter && upper) begin
            ascii_next = base_ascii - ASCII_CASE_OFFSET;
        end else begin
            ascii_next = base_ascii;
        end
    end

    // --------------------------------------------------
    // output register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_out.valid <= 1'b0;
        end else begin
            key_out.valid <= key_event.valid;
            if (key_event.valid) begin
                key_out.released <= key_event.released;
                key_out.extended <= key_event.extended;
                key_out.shift    <= key_event.shift;
                key_out.caps     <= key_event.caps;
                key_out.code     <= key_event.code;
                key_out.ascii    <= ascii_next;
            end
        end
    end

endmodule

// ==== hdl/scan_decoder.sv ====
`timescale 1ns/1ps
`include "ps2_settings.svh"

module scan_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ps2_frame_pkg::ps2_byte_t  rx_byte,
    output key_event_pkg::key_event_t key_event
);

    logic pend_ext;
    logic pend_rel;
    logic lshift;
    logic rshift;
    logic caps;
    logic is_ext_prefix;
    logic is_rel_prefix;
    logic is_lshift;
    logic is_rshift;
    logic is_caps;
    logic is_modifier;
    logic key_done;

    // --------------------------------------------------
    // byte classification
    // --------------------------------------------------
    assign is_ext_prefix = (rx_byte.data == `SCAN_EXTENDED);
    assign is_rel_prefix = (rx_byte.data == `SCAN_BREAK);

    // modifiers only without the E0 prefix
    assign is_lshift   = ~pend_ext & (rx_byte.data == `SCAN_LSHIFT);
    assign is_rshift   = ~pend_ext & (rx_byte.data == `SCAN_RSHIFT);
    assign is_caps     = ~pend_ext & (rx_byte.data == `SCAN_CAPS);
    assign is_modifier = is_lshift | is_rshift | is_caps;

    // any non-prefix byte ends a sequence
    assign key_done = rx_byte.valid & ~is_ext_prefix & ~is_rel_prefix;

    // --------------------------------------------------
    // prefix flags
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n || rx_byte.error) begin
            // damaged frame drops any pending prefix
            pend_ext <= 1'b0;
            pend_rel <= 1'b0;
        end else if (rx_byte.valid) begin
            if (is_ext_prefix) begin
                pend_ext <= 1'b1;
            end else if (is_rel_prefix) begin
                pend_rel <= 1'b1;
            end else begin
                pend_ext <= 1'b0;
                pend_rel <= 1'b0;
            end
        end
    end

    // shift level held per key
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lshift <= 1'b0;
            rshift <= 1'b0;
            caps   <= 1'b0;
        end else if (key_done) begin
            if (is_lshift) begin
                lshift <= ~pend_rel;
            end
            if (is_rshift) begin
                rshift <= ~pend_rel;
            end
            // toggle on make only
            if (is_caps && !pend_rel) begin
                caps <= ~caps;
            end
        end
    end

    // --------------------------------------------------
    // event register
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_event.valid <= 1'b0;
        end else begin
            key_event.valid <= key_done & ~is_modifier;
            if (key_done && !is_modifier) begin
                key_event.released <= pend_rel;
                key_event.extended <= pend_ext;
                key_event.shift    <= lshift | rshift;
                key_event.caps     <= caps;
                key_event.code     <= rx_byte.data;
            end
        end
    end

    // event carries the modifier levels that stand after it
    a_event_levels: assert property (@(posedge clk) disable iff (!rst_n)
        key_event.valid |-> (key_event.shift == (lshift | rshift)) && (key_event.caps == caps));

endmodule

// ==== hdl/ps2_frame_rx.sv ====
`timescale 1ns/1ps
`include "ps2_settings.svh"

module ps2_frame_rx (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ps2_clk,
    input  logic                     ps2_data,
    output ps2_frame_pkg::ps2_byte_t rx_byte
);
    import ps2_frame_pkg::*;

    localparam int LAST_BIT = `PS2_FRAME_BITS - 1;
    localparam int CNT_W    = $clog2(`PS2_FRAME_BITS);
    localparam int IDLE_W   = $clog2(`PS2_IDLE_LIMIT + 1);

    logic [1:0]                 clk_sync;
    logic [1:0]                 data_sync;
    logic                       clk_prev;
    logic                       fall;
    logic [CNT_W-1:0]           bit_cnt;
    logic                       last_bit;
    logic [`PS2_FRAME_BITS-1:0] frame;
    logic [`PS2_FRAME_BITS-1:0] frame_next;
    logic                       frame_ok;
    logic [IDLE_W-1:0]          idle_cnt;
    logic                       idle_expired;

    // --------------------------------------------------
    // synchronizer and falling edge detect
    // --------------------------------------------------
    // lines idle high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    // one-cycle pulse on the third cycle after the pin falls
    assign fall = clk_prev & ~clk_sync[1];

    // --------------------------------------------------
    // bit capture
    // --------------------------------------------------
    assign last_bit = (bit_cnt == CNT_W'(LAST_BIT));

    // frame including the bit taken on this edge
    always_comb begin
        frame_next = frame;
        if (fall) begin
            frame_next[bit_cnt] = data_sync[1];
        end
    end

    always_ff @(posedge clk) begin
        frame <= frame_next;
    end

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame_next[0] & frame_next[LAST_BIT] & (^frame_next[LAST_BIT-1:1]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (fall) begin
            bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
        end else if (idle_expired) begin
            // drop a half frame left behind
            bit_cnt <= '0;
        end
    end

    // --------------------------------------------------
    // idle watchdog
    // --------------------------------------------------
    assign idle_expired = (idle_cnt == IDLE_W'(`PS2_IDLE_LIMIT));

    always_ff @(posedge clk) begin
        if (!rst_n || fall) begin
            idle_cnt <= '0;
        end else if (!idle_expired) begin
            idle_cnt <= idle_cnt + 1'b1;
        end
    end

    // data only moves on a good frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_byte.valid <= 1'b0;
            rx_byte.error <= 1'b0;
        end else begin
            rx_byte.valid <= fall & last_bit & frame_ok;
            rx_byte.error <= fall & last_bit & ~frame_ok;
            if (fall && last_bit && frame_ok) begin
                rx_byte.data <= frame_next[PS2_DATA_BITS:1];
            end
        end
    end

    // no two edges back to back, so strobes last one cycle
    a_strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_byte.valid || rx_byte.error) |=> !(rx_byte.valid || rx_byte.error));

    a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        bit_cnt <= CNT_W'(LAST_BIT));

endmodule

// ==== hdl/key_event_pkg.sv ====
package key_event_pkg;

    // --------------------------------------------------
    // decoded key side types
    // --------------------------------------------------

    // ascii values the mapper produces besides letters and digits
    localparam logic [7:0] ASCII_NONE        = 8'h00;
    localparam logic [7:0] ASCII_SPACE       = 8'h20;
    localparam logic [7:0] ASCII_ENTER       = 8'h0D;
    localparam logic [7:0] ASCII_BACKSPACE   = 8'h08;
    // distance from lower to upper case
    localparam logic [7:0] ASCII_CASE_OFFSET = 8'h20;

    // one key, prefixes already folded in
    typedef struct packed {
        logic       valid;
        logic       released;
        logic       extended;
        // modifier levels after this key
        logic       shift;
        logic       caps;
        logic [7:0] code;
    } key_event_t;

    // same fields as key_event_t, plus the ascii lookup result
    typedef struct packed {
        logic       valid;
        logic       released;
        logic       extended;
        logic       shift;
        logic       caps;
        logic [7:0] code;
        // zero when the key has no ascii meaning
        logic [7:0] ascii;
    } ascii_out_t;

endpackage

// ==== hdl/ps2_frame_pkg.sv ====
package ps2_frame_pkg;

    // --------------------------------------------------
    // serial frame side types
    // --------------------------------------------------

    // payload bits in one ps2 frame
    localparam int PS2_DATA_BITS = 8;

    // one received frame, after start/stop/parity check
    typedef struct packed {
        // one-cycle strobe, frame was good
        logic                     valid;
        // one-cycle strobe, start, stop or parity bad
        logic                     error;
        // last good byte, held between strobes
        logic [PS2_DATA_BITS-1:0] data;
    } ps2_byte_t;

endpackage

// ==== hdl/ps2_settings.svh ====
`ifndef PS2_SETTINGS_SVH
`define PS2_SETTINGS_SVH

// --------------------------------------------------
// frame format
// --------------------------------------------------
// start + 8 data + parity + stop
`define PS2_FRAME_BITS 11

// clk cycles with no ps2 clock edge before a partial frame is dropped
`define PS2_IDLE_LIMIT 4096

// --------------------------------------------------
// scan-code set 2 specials
// --------------------------------------------------
`define SCAN_EXTENDED 8'hE0
`define SCAN_BREAK    8'hF0
`define SCAN_LSHIFT   8'h12
`define SCAN_RSHIFT   8'h59
`define SCAN_CAPS     8'h58

`endif
